/* source/noc_cfg_pkg.sv */
// Topology and sizing of the 2x2 XY mesh
// Only square meshes are supported, and the queue depth applies to every router input

package noc_cfg_pkg;

  // --------------------
  // Mesh dimensions
  // --------------------
  localparam int x_nodes   = 2;
  localparam int y_nodes   = 2;
  localparam int num_ports = x_nodes * y_nodes;

  // Width of a node number, big enough for num_ports nodes
  localparam int node_w = 2;

  // Input queue sizing, with the pointer and count widths derived from the depth
  localparam int queue_depth = 4;
  localparam int qptr_w      = $clog2(queue_depth);
  localparam int qcnt_w      = $clog2(queue_depth + 1);

  // --------------------
  // Router ports
  // --------------------
  localparam int router_ports = 5;
  localparam int port_w       = $clog2(router_ports);

  // Port indices double as link directions, with row 0 on the south edge
  localparam logic [port_w-1:0] port_local = port_w'(0);
  localparam logic [port_w-1:0] port_north = port_w'(1);
  localparam logic [port_w-1:0] port_east  = port_w'(2);
  localparam logic [port_w-1:0] port_south = port_w'(3);
  localparam logic [port_w-1:0] port_west  = port_w'(4);

endpackage

/* source/noc_pkt_pkg.sv */
// Packet format and node coordinate helpers
// Packets are single flit, and the valid bit travels inside the packet

package noc_pkt_pkg;

  import noc_cfg_pkg::*;

  // --------------------
  // Packet
  // --------------------

  // One flit carries the whole packet, valid sits in the top bit
  typedef struct packed {
    logic              valid;
    logic [node_w-1:0] src;
    logic [node_w-1:0] dest;
    // Sequence tag chosen by the sender
    logic [7:0]        seq;
    logic [15:0]       data;
  } packet_t;

  // --------------------
  // Node coordinates
  // --------------------

  // Node number is row * x_nodes + column
  function automatic int node_x(input logic [node_w-1:0] node);
    return int'(node) % x_nodes;
  endfunction

  // Row of a node, where row 0 is the south edge of the mesh
  function automatic int node_y(input logic [node_w-1:0] node);
    return int'(node) / x_nodes;
  endfunction

endpackage

/* source/input_queue.sv */
// Packet FIFO for one router input, valid/ready on both sides
// Ready depends on occupancy only, so a full queue refuses even if a read is pending

`timescale 1ns/1ns

module input_queue (
  input  logic                 clk,
  input  logic                 rst_n,
  input  noc_pkt_pkg::packet_t in_pkt,
  input  logic                 in_valid,
  output logic                 in_ready,
  output noc_pkt_pkg::packet_t out_pkt,
  output logic                 out_valid,
  input  logic                 out_ready
);

  import noc_cfg_pkg::*;
  import noc_pkt_pkg::*;

  packet_t           mem [queue_depth];
  logic [qptr_w-1:0] wr_ptr;
  logic [qptr_w-1:0] rd_ptr;
  logic [qcnt_w-1:0] count;
  logic              push;
  logic              pop;

  // Pointers wrap at the depth, which need not be a power of two
  function automatic logic [qptr_w-1:0] next_ptr(input logic [qptr_w-1:0] ptr);
    return (ptr == qptr_w'(queue_depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Accept while there is room left in the buffer
  assign in_ready  = count < qcnt_w'(queue_depth);
  // The head entry is visible whenever something is held
  assign out_valid = count != '0;
  assign out_pkt   = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  // Pointer and occupancy bookkeeping, a push and a pop may share a cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (pop)  rd_ptr <= next_ptr(rd_ptr);
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= in_pkt;
  end

endmodule

/* source/xy_router.sv */
// Five-port mesh router with XY routing and a round-robin arbiter per output
// Adds one register stage per hop after the input queue; edge ports stay idle

`timescale 1ns/1ns

module xy_router #(
  parameter int router_x = 0,
  parameter int router_y = 0
) (
  input  logic                                                 clk,
  input  logic                                                 rst_n,
  input  noc_pkt_pkg::packet_t [noc_cfg_pkg::router_ports-1:0] in_pkt,
  output logic                 [noc_cfg_pkg::router_ports-1:0] in_ready,
  output noc_pkt_pkg::packet_t [noc_cfg_pkg::router_ports-1:0] out_pkt,
  input  logic                 [noc_cfg_pkg::router_ports-1:0] out_ready
);

  import noc_cfg_pkg::*;
  import noc_pkt_pkg::*;

  // Queue heads, indexed by input port
  packet_t [router_ports-1:0] q_pkt;
  logic    [router_ports-1:0] q_valid;
  logic    [router_ports-1:0] q_pop;
  // Output port chosen for each head
  logic    [port_w-1:0]       route [router_ports];

  // Grant matrix, one vector of inputs per output
  logic    [router_ports-1:0] grant [router_ports];
  logic    [port_w-1:0]       win_idx [router_ports];
  logic    [router_ports-1:0] can_load;
  logic    [port_w-1:0]       rr_ptr [router_ports];

  // Output registers, valid kept apart from the payload
  packet_t [router_ports-1:0] out_data;
  logic    [router_ports-1:0] out_vld;

  // --------------------
  // Input queues
  // --------------------
  for (genvar p = 0; p < router_ports; p++) begin : g_queue
    input_queue u_queue (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_pkt    (in_pkt[p]),
      .in_valid  (in_pkt[p].valid),
      .in_ready  (in_ready[p]),
      .out_pkt   (q_pkt[p]),
      .out_valid (q_valid[p]),
      .out_ready (q_pop[p])
    );
  end

  // --------------------
  // XY route
  // --------------------
  // Column is fixed first, then the row, and a match on both ejects locally
  always_comb begin
    int dest_x;
    int dest_y;
    for (int i = 0; i < router_ports; i++) begin
      dest_x = node_x(q_pkt[i].dest);
      dest_y = node_y(q_pkt[i].dest);
      if (dest_x > router_x) begin
        route[i] = port_east;
      end else if (dest_x < router_x) begin
        route[i] = port_west;
      end else if (dest_y > router_y) begin
        route[i] = port_north;
      end else if (dest_y < router_y) begin
        route[i] = port_south;
      end else begin
        route[i] = port_local;
      end
    end
  end

  // --------------------
  // Round-robin arbiters
  // --------------------
  // An output may take a new packet when its register is empty or draining now
  assign can_load = ~out_vld | out_ready;

  always_comb begin
    int  idx;
    logic found;
    for (int o = 0; o < router_ports; o++) begin
      grant[o]   = '0;
      win_idx[o] = rr_ptr[o];
      found      = 1'b0;
      // Search starts at the pointer and wraps around all inputs
      for (int k = 0; k < router_ports; k++) begin
        idx = int'(rr_ptr[o]) + k;
        if (idx >= router_ports) idx = idx - router_ports;
        if (!found && can_load[o] && q_valid[idx] && route[idx] == port_w'(o)) begin
          grant[o][idx] = 1'b1;
          win_idx[o]    = port_w'(idx);
          found         = 1'b1;
        end
      end
    end
  end

  // Each head requests one output only, so at most one grant pops it
  always_comb begin
    for (int i = 0; i < router_ports; i++) begin
      q_pop[i] = 1'b0;
      for (int o = 0; o < router_ports; o++) begin
        q_pop[i] = q_pop[i] | grant[o][i];
      end
    end
  end

  // --------------------
  // Output registers
  // --------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_vld <= '0;
      for (int o = 0; o < router_ports; o++) rr_ptr[o] <= '0;
    end else begin
      for (int o = 0; o < router_ports; o++) begin
        if (|grant[o]) begin
          out_vld[o] <= 1'b1;
          // Priority moves just past the winner
          rr_ptr[o]  <= (win_idx[o] == port_w'(router_ports - 1)) ? '0 : win_idx[o] + 1'b1;
        end else if (out_ready[o]) begin
          out_vld[o] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int o = 0; o < router_ports; o++) begin
      if (|grant[o]) out_data[o] <= q_pkt[win_idx[o]];
    end
  end

  // The packet's own valid bit follows the reset-cleared flag
  always_comb begin
    for (int o = 0; o < router_ports; o++) begin
      out_pkt[o]       = out_data[o];
      out_pkt[o].valid = out_vld[o];
    end
  end

endmodule

/* source/mesh_network.sv */
// 2x2 mesh of XY routers, no state outside the routers
// Row 0 is the south edge; edge inputs are idle and edge readies are held low

`timescale 1ns/1ns

module mesh_network (
  input  logic                                              clk,
  input  logic                                              rst_n,
  input  noc_pkt_pkg::packet_t [noc_cfg_pkg::num_ports-1:0] local_in,
  output logic                 [noc_cfg_pkg::num_ports-1:0] local_ready,
  output noc_pkt_pkg::packet_t [noc_cfg_pkg::num_ports-1:0] local_out,
  input  logic                 [noc_cfg_pkg::num_ports-1:0] local_accept
);

  import noc_cfg_pkg::*;
  import noc_pkt_pkg::*;

  // Per-router port bundles, first index is the node number
  packet_t [router_ports-1:0] r_in       [num_ports];
  logic    [router_ports-1:0] r_in_ready [num_ports];
  packet_t [router_ports-1:0] r_out      [num_ports];
  logic    [router_ports-1:0] r_out_rdy  [num_ports];

  for (genvar n = 0; n < num_ports; n++) begin : g_node
    localparam int col = n % x_nodes;
    localparam int row = n / x_nodes;

    xy_router #(
      .router_x (col),
      .router_y (row)
    ) u_router (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_pkt    (r_in[n]),
      .in_ready  (r_in_ready[n]),
      .out_pkt   (r_out[n]),
      .out_ready (r_out_rdy[n])
    );

    // --------------------
    // Local port
    // --------------------
    assign r_in[n][port_local]      = local_in[n];
    assign local_ready[n]           = r_in_ready[n][port_local];
    assign local_out[n]             = r_out[n][port_local];
    assign r_out_rdy[n][port_local] = local_accept[n];

    // East link pairs with the west port of the next column
    if (col < x_nodes - 1) begin : g_east
      assign r_in[n][port_east]      = r_out[n+1][port_west];
      assign r_out_rdy[n][port_east] = r_in_ready[n+1][port_west];
    end else begin : g_east_edge
      assign r_in[n][port_east]      = '0;
      assign r_out_rdy[n][port_east] = 1'b0;
    end

    // West link pairs with the east port of the previous column
    if (col > 0) begin : g_west
      assign r_in[n][port_west]      = r_out[n-1][port_east];
      assign r_out_rdy[n][port_west] = r_in_ready[n-1][port_east];
    end else begin : g_west_edge
      assign r_in[n][port_west]      = '0;
      assign r_out_rdy[n][port_west] = 1'b0;
    end

    // North is one row up, a full row of nodes further on
    if (row < y_nodes - 1) begin : g_north
      assign r_in[n][port_north]      = r_out[n+x_nodes][port_south];
      assign r_out_rdy[n][port_north] = r_in_ready[n+x_nodes][port_south];
    end else begin : g_north_edge
      assign r_in[n][port_north]      = '0;
      assign r_out_rdy[n][port_north] = 1'b0;
    end

    if (row > 0) begin : g_south
      assign r_in[n][port_south]      = r_out[n-x_nodes][port_north];
      assign r_out_rdy[n][port_south] = r_in_ready[n-x_nodes][port_north];
    end else begin : g_south_edge
      assign r_in[n][port_south]      = '0;
      assign r_out_rdy[n][port_south] = 1'b0;
    end
  end

endmodule

/* source/network.sv */
// Emulation-style wrapper around the mesh, square meshes only
// A packet is taken when its valid is high and net_full is low; deliveries never stall

`timescale 1ns/1ns

module network (
  input  logic                 clk,
  input  logic                 rst_n,
  input  noc_pkt_pkg::packet_t pkt_in   [noc_cfg_pkg::num_ports],
  output noc_pkt_pkg::packet_t pkt_out  [noc_cfg_pkg::num_ports],
  output logic [0:noc_cfg_pkg::num_ports-1] net_full
);

  import noc_cfg_pkg::*;
  import noc_pkt_pkg::*;

  // Packed copies of the emulation arrays for the mesh ports
  packet_t [num_ports-1:0] mesh_in;
  packet_t [num_ports-1:0] mesh_out;
  logic    [num_ports-1:0] mesh_ready;

  always_comb begin
    for (int i = 0; i < num_ports; i++) begin
      mesh_in[i]       = pkt_in[i];
      // Qualify with ready so a packet offered while full is never half-taken
      mesh_in[i].valid = pkt_in[i].valid && mesh_ready[i];
      pkt_out[i]       = mesh_out[i];
      // Full is just the local queue refusing
      net_full[i]      = ~mesh_ready[i];
    end
  end

  // The emulation side always takes a delivered packet
  mesh_network u_mesh (
    .clk          (clk),
    .rst_n        (rst_n),
    .local_in     (mesh_in),
    .local_ready  (mesh_ready),
    .local_out    (mesh_out),
    .local_accept ({num_ports{1'b1}})
  );

endmodule

/* tests/tb_clock_gen.sv */
// Testbench clock and reset source
// Reset is released on a falling edge after the given number of rising edges

`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int period_ns    = 4,
  parameter int reset_cycles = 4
) (
  output logic clk,
  output logic rst_n
);

  // Free-running clock, low at time zero
  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  // Synchronous active-low reset, held for reset_cycles rising edges
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

/* tests/network_tb.sv */
// Testbench for the 2x2 mesh behind the emulation-style wrapper
// Inputs change on the falling edge, outputs are checked on the rising edge

`timescale 1ns/1ns

module network_tb;

  import noc_cfg_pkg::*;
  import noc_pkt_pkg::*;

  // Packets per port in each phase, and the watchdog budget derived from them
  localparam int light_quota     = 30;
  localparam int hot_quota       = 24;
  localparam int total_pkts      = num_ports * (light_quota + hot_quota);
  localparam int watchdog_cycles = total_pkts * 40 + 200;
  // Drain budget, well inside the watchdog so that a lost packet shows up as a count
  localparam int drain_cycles    = total_pkts * 8;

  logic    clk;
  logic    rst_n;
  packet_t pkt_in  [num_ports];
  packet_t pkt_out [num_ports];
  logic [0:num_ports-1] net_full;

  // One scoreboard queue per source and destination pair, index src * num_ports + dest
  packet_t    sb_q    [num_ports*num_ports][$];
  logic [7:0] seq_cnt [num_ports*num_ports];
  // A packet that is on pkt_in but not yet taken by the network
  logic       hold    [num_ports];

  integer seed;
  string  test_name;
  logic   in_hotspot;
  logic   saw_full;
  int     reset_edges;
  logic   was_reset;
  int     drain_cnt;

  tb_clock_gen #(.period_ns(4), .reset_cycles(4)) u_clock (
    .clk   (clk),
    .rst_n (rst_n)
  );

  network u_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .pkt_in   (pkt_in),
    .pkt_out  (pkt_out),
    .net_full (net_full)
  );

  // --------------------
  // Helpers
  // --------------------
  task automatic abort_run(input string line);
    $display("%s", line);
    $display("test failed");
    $fatal(1);
  endtask

  // Packets accepted by the network but not yet delivered
  function automatic int outstanding();
    int total;
    total = 0;
    for (int p = 0; p < num_ports * num_ports; p++) total += sb_q[p].size();
    return total;
  endfunction

  // Idle outputs are expected in reset and on the first cycle after it
  task automatic check_idle();
    assert (net_full == '0) else
      abort_run($sformatf("Fail %s net_full expected 0000 actual %b", test_name, net_full));
    for (int i = 0; i < num_ports; i++) begin
      assert (pkt_out[i].valid === 1'b0) else
        abort_run($sformatf("Fail %s pkt_out[%0d].valid expected 0 actual %b",
                            test_name, i, pkt_out[i].valid));
    end
  endtask

  // A delivery must match the oldest outstanding packet of its pair, which also checks order
  task automatic check_delivery(input int port);
    packet_t got;
    packet_t head;
    int      pair;
    got = pkt_out[port];
    assert (got.dest == node_w'(port)) else
      abort_run($sformatf("Fail %s dest at port %0d expected %0d actual %0d",
                          test_name, port, port, got.dest));
    pair = int'(got.src) * num_ports + port;
    assert (sb_q[pair].size() > 0) else
      abort_run($sformatf(
        "%s: node %0d (x %0d, y %0d) delivered a packet to port %0d that was never sent",
        test_name, got.src, node_x(got.src), node_y(got.src), port));
    head = sb_q[pair].pop_front();
    assert (got.seq == head.seq) else
      abort_run($sformatf("Fail %s seq from %0d to %0d expected %0d actual %0d",
                          test_name, got.src, port, head.seq, got.seq));
    assert (got.data == head.data) else
      abort_run($sformatf("Fail %s data from %0d to %0d expected %h actual %h",
                          test_name, got.src, port, head.data, got.data));
  endtask

  // --------------------
  // Stimulus
  // --------------------
  // Each port offers up to quota packets; rate is the chance in quarters of offering a new one
  task automatic drive_phase(input int quota, input logic hotspot, input int rate);
    int      sent [num_ports];
    logic    busy;
    packet_t p;
    int      pair;
    for (int i = 0; i < num_ports; i++) sent[i] = 0;
    busy = 1'b1;
    while (busy) begin
      @(negedge clk);
      busy = 1'b0;
      for (int i = 0; i < num_ports; i++) begin
        if (!hold[i]) begin
          if (sent[i] < quota && ($random(seed) & 3) < rate) begin
            p       = '0;
            p.valid = 1'b1;
            p.src   = node_w'(i);
            p.dest  = hotspot ? '0 : node_w'($random(seed));
            p.data  = 16'($random(seed));
            pair    = i * num_ports + int'(p.dest);
            p.seq   = seq_cnt[pair];
            seq_cnt[pair] = seq_cnt[pair] + 8'd1;
            pkt_in[i] = p;
            hold[i]   = 1'b1;
            sent[i]++;
          end else begin
            pkt_in[i] = '0;
          end
        end
        // net_full only moves on a rising edge, so its value now decides the next edge
        if (hold[i] && !net_full[i]) begin
          sb_q[i * num_ports + int'(pkt_in[i].dest)].push_back(pkt_in[i]);
          hold[i] = 1'b0;
        end
        if (hold[i] || sent[i] < quota) busy = 1'b1;
      end
    end
    // The last taken packets leave pkt_in after their edge
    @(negedge clk);
    for (int i = 0; i < num_ports; i++) pkt_in[i] = '0;
  endtask

  initial begin
    seed       = 32'h35e93473;
    test_name  = "reset";
    in_hotspot = 1'b0;
    saw_full   = 1'b0;
    drain_cnt  = 0;
    for (int i = 0; i < num_ports; i++) begin
      pkt_in[i] = '0;
      hold[i]   = 1'b0;
    end
    for (int p = 0; p < num_ports * num_ports; p++) seq_cnt[p] = '0;
    wait (rst_n === 1'b1);

    test_name = "light";
    drive_phase(light_quota, 1'b0, 1);

    // Every port floods node 0, so back-pressure has to reach the sources
    test_name  = "hotspot";
    in_hotspot = 1'b1;
    drive_phase(hot_quota, 1'b1, 4);
    in_hotspot = 1'b0;
    assert (saw_full) else
      abort_run("hotspot: net_full never rose while all ports were sending to node 0");

    // Deliveries are counted on the rising edge, so the count is read between edges
    test_name = "drain";
    while (outstanding() != 0 && drain_cnt < drain_cycles) begin
      @(negedge clk);
      drain_cnt++;
    end
    // A few more cycles so that a duplicate delivery would still be caught
    repeat (20) @(negedge clk);
    assert (outstanding() == 0) else
      abort_run($sformatf("Fail %s outstanding packets expected 0 actual %0d",
                          test_name, outstanding()));
    $display("test passed");
    $finish;
  end

  // --------------------
  // Checks on the rising edge
  // --------------------
  initial begin
    reset_edges = 0;
    was_reset   = 1'b0;
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      // State is unknown until the first reset edge has been applied
      if (reset_edges > 0) check_idle();
      reset_edges++;
      was_reset = 1'b1;
    end else begin
      if (was_reset) check_idle();
      was_reset = 1'b0;
      if (in_hotspot && net_full != '0) saw_full = 1'b1;
      for (int i = 0; i < num_ports; i++) begin
        if (pkt_out[i].valid === 1'b1) check_delivery(i);
      end
    end
  end

  // Watchdog
  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    abort_run($sformatf("watchdog expired in phase %s with %0d packets still outstanding",
                        test_name, outstanding()));
  end

endmodule

/* mesh_noc.f */
source/noc_cfg_pkg.sv
source/noc_pkt_pkg.sv
source/input_queue.sv
source/xy_router.sv
source/mesh_network.sv
source/network.sv
tests/tb_clock_gen.sv
tests/network_tb.sv
